// File: hci_pkg.sv
`default_nettype none

package hci_pkg;

  // bank count and wide port width in 32-bit lanes
  localparam int unsigned NB_OUT_CHAN = 8;
  localparam int unsigned NB_IN_CHAN  = 4;

  // byte address, bank offset and bank row widths
  localparam int unsigned ADDR_W          = 12;
  localparam int unsigned BANK_SEL_W      = 3;
  localparam int unsigned ROW_W           = ADDR_W - 5;
  // first address bit above the bank offset
  localparam int unsigned LSB_COMMON_ADDR = 5;

  // wide port data and byte enable widths
  localparam int unsigned WIDE_DW = 128;
  localparam int unsigned WIDE_BW = 16;

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [ROW_W-1:0]      row_t;
  typedef logic [BANK_SEL_W-1:0] bank_sel_t;
  typedef logic [31:0]           word_t;
  typedef logic [3:0]            strb_t;

  // wide accelerator request, wen high means read
  typedef struct packed {
    logic               req;
    logic               wen;
    addr_t              add;
    logic [WIDE_BW-1:0] be;
    logic [WIDE_DW-1:0] data;
  } hci_wide_req_t;

  typedef struct packed {
    logic               gnt;
    logic               r_valid;
    logic [WIDE_DW-1:0] r_data;
  } hci_wide_rsp_t;

  // one 32-bit lane or bank port, addressed by bank row
  typedef struct packed {
    logic  req;
    logic  wen;
    row_t  row;
    strb_t be;
    word_t data;
  } hci_bank_req_t;

  typedef struct packed {
    logic  gnt;
    logic  r_valid;
    word_t r_data;
  } hci_bank_rsp_t;

endpackage

`default_nettype wire

// File: hci_router_reorder.sv
`timescale 1ns/10ps
`default_nettype none

module hci_router_reorder (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  hci_pkg::bank_sel_t     order_i,
  input  hci_pkg::hci_bank_req_t lane_req_i [hci_pkg::NB_IN_CHAN],
  output hci_pkg::hci_bank_rsp_t lane_rsp_o [hci_pkg::NB_IN_CHAN],
  output hci_pkg::hci_bank_req_t bank_req_o [hci_pkg::NB_OUT_CHAN],
  input  hci_pkg::hci_bank_rsp_t bank_rsp_i [hci_pkg::NB_OUT_CHAN]
);

  import hci_pkg::*;

  // offset of the request granted in the previous cycle
  bank_sel_t order_q;

  // request side: lane ii lands on bank (order + ii) mod 8
  always_comb begin
    bank_sel_t bank_idx;
    // banks without a lane see an all-zero request, so req stays low
    for (int bb = 0; bb < NB_OUT_CHAN; bb++) begin
      bank_req_o[bb] = '0;
    end
    for (int ii = 0; ii < NB_IN_CHAN; ii++) begin
      // 3-bit sum wraps around the last bank
      bank_idx = order_i + bank_sel_t'(ii);
      bank_req_o[bank_idx] = lane_req_i[ii];
    end
  end

  // response side
  always_comb begin
    bank_sel_t gnt_idx;
    bank_sel_t rsp_idx;
    for (int ii = 0; ii < NB_IN_CHAN; ii++) begin
      // grant comes back in the request cycle, so the live offset applies
      gnt_idx = order_i + bank_sel_t'(ii);
      // read data belongs to last cycle's request, so use its offset
      rsp_idx = order_q + bank_sel_t'(ii);
      lane_rsp_o[ii].gnt     = bank_rsp_i[gnt_idx].gnt;
      lane_rsp_o[ii].r_valid = bank_rsp_i[rsp_idx].r_valid;
      lane_rsp_o[ii].r_data  = bank_rsp_i[rsp_idx].r_data;
    end
  end

  // capture the offset on each handshake of lane 0
  // all lanes share req, so lane 0 stands for the whole wide access
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      order_q <= '0;
    end else if (clear_i) begin
      order_q <= '0;
    end else if (lane_req_i[0].req && lane_rsp_o[0].gnt) begin
      order_q <= order_i;
    end
  end

endmodule

`default_nettype wire

// File: hci_router.sv
`timescale 1ns/10ps
`default_nettype none

module hci_router (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  hci_pkg::hci_wide_req_t wide_req_i,
  output hci_pkg::hci_wide_rsp_t wide_rsp_o,
  output hci_pkg::hci_bank_req_t bank_req_o [hci_pkg::NB_OUT_CHAN],
  input  hci_pkg::hci_bank_rsp_t bank_rsp_i [hci_pkg::NB_OUT_CHAN]
);

  import hci_pkg::*;

  // word-interleaved address split
  // [1:0] byte in word, ignored
  // [4:2] bank of lane 0
  // [11:5] row shared by all lanes that do not wrap
  bank_sel_t bank_offset;
  row_t      row_base;
  row_t      row_next;

  // virtual 32-bit lanes between the wide port and the reorder block
  hci_bank_req_t lane_req [NB_IN_CHAN];
  hci_bank_rsp_t lane_rsp [NB_IN_CHAN];

  // lane read data packed back into lane order
  logic [WIDE_DW-1:0] rdata_wide;

  // handshake of the previous cycle, filters r_valid
  logic gnt_q;

  assign bank_offset = wide_req_i.add[LSB_COMMON_ADDR-1:2];
  assign row_base    = wide_req_i.add[ADDR_W-1:LSB_COMMON_ADDR];
  // row for lanes past the last bank, wraps at the top row
  assign row_next    = row_base + row_t'(1);

  always_comb begin
    for (int ii = 0; ii < NB_IN_CHAN; ii++) begin
      // req and wen are common to every lane
      lane_req[ii].req  = wide_req_i.req;
      lane_req[ii].wen  = wide_req_i.wen;
      lane_req[ii].be   = wide_req_i.be[4*ii +: 4];
      lane_req[ii].data = wide_req_i.data[32*ii +: 32];
      // lane rolled over bank 7 into bank 0 of the next row
      if (int'(bank_offset) + ii >= int'(NB_OUT_CHAN)) begin
        lane_req[ii].row = row_next;
      end else begin
        lane_req[ii].row = row_base;
      end
    end
  end

  always_comb begin
    for (int ii = 0; ii < NB_IN_CHAN; ii++) begin
      rdata_wide[32*ii +: 32] = lane_rsp[ii].r_data;
    end
  end

  // lane 0 speaks for the wide port
  // gnt only where req is asserted, r_valid only after a real grant
  always_comb begin
    wide_rsp_o.gnt     = lane_rsp[0].gnt & wide_req_i.req;
    wide_rsp_o.r_valid = lane_rsp[0].r_valid & gnt_q;
    wide_rsp_o.r_data  = rdata_wide;
  end

  // TCDM: r_valid is due exactly one cycle after the handshake
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q <= 1'b0;
    end else if (clear_i) begin
      gnt_q <= 1'b0;
    end else begin
      gnt_q <= lane_rsp[0].gnt & lane_req[0].req;
    end
  end

  // rotate lanes onto banks by the offset of lane 0
  hci_router_reorder i_reorder (
    .clk_i      ( clk_i       ),
    .rst_ni     ( rst_ni      ),
    .clear_i    ( clear_i     ),
    .order_i    ( bank_offset ),
    .lane_req_i ( lane_req    ),
    .lane_rsp_o ( lane_rsp    ),
    .bank_req_o ( bank_req_o  ),
    .bank_rsp_i ( bank_rsp_i  )
  );

endmodule

`default_nettype wire

// File: tcdm_bank.sv
`timescale 1ns/10ps
`default_nettype none

module tcdm_bank (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  hci_pkg::hci_bank_req_t req_i,
  output hci_pkg::hci_bank_rsp_t rsp_o
);

  import hci_pkg::*;

  // one word per row
  word_t mem_q [2**ROW_W];
  word_t rdata_q;
  logic  rvalid_q;

  // write, wen low, only the enabled bytes change
  always_ff @(posedge clk_i) begin
    if (req_i.req && !req_i.wen) begin
      for (int bb = 0; bb < $bits(strb_t); bb++) begin
        if (req_i.be[bb]) begin
          mem_q[req_i.row][8*bb +: 8] <= req_i.data[8*bb +: 8];
        end
      end
    end
  end

  // read, wen high, word shows up on r_data the next cycle
  // after a write, r_data keeps the old word
  always_ff @(posedge clk_i) begin
    if (req_i.req && req_i.wen) begin
      rdata_q <= mem_q[req_i.row];
    end
  end

  // single initiator, so every req is granted and r_valid follows the grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  always_comb begin
    rsp_o.gnt     = req_i.req;
    rsp_o.r_valid = rvalid_q;
    rsp_o.r_data  = rdata_q;
  end

endmodule

`default_nettype wire

// File: hci_bank_subsys.sv
`timescale 1ns/10ps
`default_nettype none

module hci_bank_subsys (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  hci_pkg::hci_wide_req_t wide_req_i,
  output hci_pkg::hci_wide_rsp_t wide_rsp_o
);

  import hci_pkg::*;

  // one request and one response per bank
  hci_bank_req_t bank_req [NB_OUT_CHAN];
  hci_bank_rsp_t bank_rsp [NB_OUT_CHAN];

  // wide port to eight word-interleaved bank ports
  hci_router i_router (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .clear_i    ( clear_i    ),
    .wide_req_i ( wide_req_i ),
    .wide_rsp_o ( wide_rsp_o ),
    .bank_req_o ( bank_req   ),
    .bank_rsp_i ( bank_rsp   )
  );

  // bank bb holds every word whose address bits [4:2] equal bb
  for (genvar bb = 0; bb < NB_OUT_CHAN; bb++) begin : gen_bank
    tcdm_bank i_bank (
      .clk_i  ( clk_i        ),
      .rst_ni ( rst_ni       ),
      .req_i  ( bank_req[bb] ),
      .rsp_o  ( bank_rsp[bb] )
    );
  end

endmodule

`default_nettype wire

// File: hci_router_sva.sv
`timescale 1ns/10ps
`default_nettype none

module hci_router_sva (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   clear_i,
  input hci_pkg::hci_wide_req_t wide_req_i,
  input hci_pkg::hci_wide_rsp_t wide_rsp_o
);

  // handshake that owes an r_valid in the next cycle
  logic hs;

  assign hs = wide_req_i.req & wide_rsp_o.gnt & ~clear_i;

  // r_valid exactly one cycle after the grant
  rvalid_after_gnt: assert property (
    @(posedge clk_i) disable iff (!rst_ni) hs |=> wide_rsp_o.r_valid
  ) else $error("r_valid missing one cycle after a grant");

  // gnt mirrors req as the banks never stall
  gnt_equals_req: assert property (
    @(posedge clk_i) wide_rsp_o.gnt == wide_req_i.req
  ) else $error("gnt differs from req");

  no_rvalid_in_reset: assert property (
    @(posedge clk_i) !rst_ni |-> !wide_rsp_o.r_valid
  ) else $error("r_valid high during reset");

endmodule

bind hci_router hci_router_sva i_router_sva (
  .clk_i      ( clk_i      ),
  .rst_ni     ( rst_ni     ),
  .clear_i    ( clear_i    ),
  .wide_req_i ( wide_req_i ),
  .wide_rsp_o ( wide_rsp_o )
);

`default_nettype wire

// File: tb_hci_bank_subsys.sv
`timescale 1ns/10ps
`default_nettype none

module tb_hci_bank_subsys;

  import hci_pkg::*;

  localparam int GNT_TIMEOUT = 20;

  logic          clk;
  logic          rst_n;
  logic          clear;
  hci_wide_req_t wide_req;
  hci_wide_rsp_t wide_rsp;

  // reference copy of all eight banks, indexed by add[11:2]
  word_t ref_mem [1024];

  // response due at the next falling edge
  logic               pend_valid;
  logic               pend_read;
  logic [WIDE_DW-1:0] pend_data;
  logic [WIDE_DW-1:0] last_rdata;

  int errors;
  int checks;
  int seed;

  hci_bank_subsys DUT (
    .clk_i      ( clk      ),
    .rst_ni     ( rst_n    ),
    .clear_i    ( clear    ),
    .wide_req_i ( wide_req ),
    .wide_rsp_o ( wide_rsp )
  );

  always #5 clk = ~clk;

  task automatic check_val(input string name, input logic [WIDE_DW-1:0] got,
                           input logic [WIDE_DW-1:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  // lane ii of a wide access covers word w + ii, wrapping at 1024 words
  function automatic logic [9:0] word_index(input addr_t add, input int lane);
    return add[ADDR_W-1:2] + 10'(lane);
  endfunction

  // preload value, unique per word address
  function automatic word_t fill_word(input logic [9:0] idx);
    return {6'h2b, idx, ~idx, 6'h15};
  endfunction

  function automatic logic [WIDE_DW-1:0] model_read(input addr_t add);
    logic [WIDE_DW-1:0] rd;
    for (int ii = 0; ii < NB_IN_CHAN; ii++) begin
      rd[32*ii +: 32] = ref_mem[word_index(add, ii)];
    end
    return rd;
  endfunction

  task automatic model_write(input addr_t add, input logic [WIDE_BW-1:0] be,
                             input logic [WIDE_DW-1:0] data);
    logic [9:0] idx;
    for (int ii = 0; ii < NB_IN_CHAN; ii++) begin
      idx = word_index(add, ii);
      for (int bb = 0; bb < 4; bb++) begin
        if (be[4*ii+bb]) begin
          ref_mem[idx][8*bb +: 8] = data[32*ii + 8*bb +: 8];
        end
      end
    end
  endtask

  // r_valid is due exactly one cycle after a grant, low otherwise
  task automatic check_pending();
    check_val("wide_rsp_o.r_valid", 128'(wide_rsp.r_valid), 128'(pend_valid));
    if (pend_valid && pend_read) begin
      check_val("wide_rsp_o.r_data", wide_rsp.r_data, pend_data);
      last_rdata = wide_rsp.r_data;
    end
    pend_valid = 1'b0;
  endtask

  // drives one request per cycle and checks the previous response first
  task automatic issue(input logic wen, input addr_t add, input logic [WIDE_BW-1:0] be,
                       input logic [WIDE_DW-1:0] data);
    int waited;
    @(negedge clk);
    check_pending();
    wide_req.req  = 1'b1;
    wide_req.wen  = wen;
    wide_req.add  = add;
    wide_req.be   = be;
    wide_req.data = data;
    waited = 0;
    #1;
    while (!wide_rsp.gnt && waited < GNT_TIMEOUT) begin
      @(negedge clk);
      #1;
      waited++;
    end
    checks++;
    assert (wide_rsp.gnt) else begin
      $display("Timeout at %0t ns: request to address %0h was never granted", $time, add);
      errors++;
    end
    pend_valid = wide_rsp.gnt;
    pend_read  = wen;
    // model follows issue order, so a read sees all earlier writes
    if (wen) begin
      pend_data = model_read(add);
    end else begin
      model_write(add, be, data);
    end
  endtask

  task automatic go_idle();
    @(negedge clk);
    check_pending();
    wide_req = '0;
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (16) begin
      @(negedge clk);
      check_val("wide_rsp_o.gnt", 128'(wide_rsp.gnt), '0);
      check_val("wide_rsp_o.r_valid", 128'(wide_rsp.r_valid), '0);
    end
    rst_n = 1'b1;
  endtask

  // every word gets a known value, back-to-back aligned writes
  task automatic preload_memory();
    logic [WIDE_DW-1:0] fill;
    for (int nn = 0; nn < 256; nn++) begin
      for (int ii = 0; ii < NB_IN_CHAN; ii++) begin
        fill[32*ii +: 32] = fill_word(10'(4*nn + ii));
      end
      issue(1'b0, addr_t'(nn*16), '1, fill);
    end
    go_idle();
  endtask

  task automatic test_aligned();
    logic [WIDE_DW-1:0] d;
    d = {$random(seed), $random(seed), $random(seed), $random(seed)};
    issue(1'b0, 12'h230, '1, d);
    issue(1'b1, 12'h230, '0, '0);
    go_idle();
    check_val("aligned read data", last_rdata, d);
  endtask

  // offsets 6 and 7 in the top row, wrapped lanes go to row 0
  task automatic test_wrap();
    logic [WIDE_DW-1:0] d;
    for (int off = 6; off < 8; off++) begin
      d = {$random(seed), $random(seed), $random(seed), $random(seed)};
      issue(1'b0, {7'h7f, 3'(off), 2'b00}, '1, d);
      issue(1'b1, {7'h7f, 3'(off), 2'b00}, '0, '0);
      go_idle();
      check_val("wrapped read data", last_rdata, d);
    end
    issue(1'b1, 12'h000, '0, '0);
    go_idle();
  endtask

  task automatic test_byte_enable();
    issue(1'b0, 12'h104, 16'ha53c, {$random(seed), $random(seed), $random(seed), $random(seed)});
    issue(1'b1, 12'h104, '0, '0);
    go_idle();
  endtask

  task automatic test_stream();
    int r;
    for (int nn = 0; nn < 64; nn++) begin
      r = $random(seed);
      issue(r[0], addr_t'(r[31:20] & 12'hffc), r[15:0],
            {$random(seed), $random(seed), $random(seed), $random(seed)});
    end
    go_idle();
  endtask

  task automatic test_reset_clear();
    repeat (3) begin
      @(negedge clk);
      check_val("wide_rsp_o.gnt", 128'(wide_rsp.gnt), '0);
      check_val("wide_rsp_o.r_valid", 128'(wide_rsp.r_valid), '0);
    end
    // clear at the grant edge drops the pending r_valid
    wide_req.req = 1'b1;
    wide_req.wen = 1'b1;
    wide_req.add = 12'h230;
    clear        = 1'b1;
    #1;
    check_val("wide_rsp_o.gnt", 128'(wide_rsp.gnt), 128'(1));
    repeat (3) begin
      @(negedge clk);
      clear    = 1'b0;
      wide_req = '0;
      check_val("wide_rsp_o.r_valid", 128'(wide_rsp.r_valid), '0);
    end
    issue(1'b1, 12'h230, '0, '0);
    go_idle();
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    clear      = 1'b0;
    wide_req   = '0;
    pend_valid = 1'b0;
    pend_read  = 1'b0;
    pend_data  = '0;
    last_rdata = '0;
    errors     = 0;
    checks     = 0;
    seed       = 32'h437b;
    apply_reset();
    preload_memory();
    test_aligned();
    test_wrap();
    test_byte_enable();
    test_stream();
    test_reset_clear();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
hci_pkg.sv
hci_router_reorder.sv
hci_router.sv
tcdm_bank.sv
hci_bank_subsys.sv
hci_router_sva.sv
tb_hci_bank_subsys.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --assert --timing -j 0 \
  --top-module tb_hci_bank_subsys \
  -f verilog.f -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -q "All tests passed" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
